/* dv/dot_vectors.txt */
# Columns: P a b last | E sum terms | H n | T name
# a, b, sum signed decimal; H withholds output credits until n more results arrive
T mixed_signs
P 3 4 1
E 12 1
P -32768 -32768 1
E 1073741824 1
P 100 -200 0
P -7 9 0
P 32767 -32768 0
P -1 -1 1
E -1073729118 4
P -5 6 0
P 12 -3 0
P 0 999 1
E -66 3
T wraparound
P 32767 32767 0
P 32767 32767 0
P 32767 32767 1
E -1073938429 3
P 32767 32767 0
P 32767 32767 0
P 32767 32767 0
P 32767 32767 0
P 32767 32767 1
E 1073414149 5
P -32768 -32768 0
P -32768 -32768 0
P -32768 32767 1
E 1073774592 3
T input_credits
P 1 2 0
P 2 2 0
P 3 2 0
P 4 2 0
P 5 2 0
P 6 2 0
P 7 2 0
P 8 2 1
E 72 8
P 1000 1000 0
P 1000 1000 0
P 1000 1000 0
P 1000 1000 0
P 1000 1000 0
P 1000 1000 1
E 6000000 6
T backpressure
H 2
P 1 1 0
P 2 2 1
E 5 2
P 3 3 1
E 9 1
P -4 4 0
P 5 -5 1
E -41 2
P 6 7 1
E 42 1
P 10 10 0
P 10 10 0
P 10 10 1
E 300 3
P -8 -8 1
E 64 1
P 2 3 0
P 4 5 1
E 26 2

/* build.f */
+incdir+hdl
hdl/dot_pkg.sv
hdl/operand_fifo.sv
hdl/mac_accum.sv
hdl/result_sender.sv
hdl/dot_product_top.sv
dv/tb_clock_gen.sv
dv/tb_dot_product.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dot_product \
    && ./obj_dir/Vtb_dot_product > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* dv/tb_dot_product.sv */
`timescale 1ns/100ps
`include "dot_settings.svh"

module tb_dot_product import dot_pkg::*; ();

    localparam int WAIT_LIMIT = 400;    // Cycles any single wait may take

    logic          clk;
    logic          rst;
    logic          in_valid   = 1'b0;
    operand_pair_t in_pair    = '0;
    logic          in_credit;
    logic          out_valid;
    dot_result_t   out_result;
    logic          out_credit = 1'b0;

    dot_result_t exp_q[$];              // Owed results in vector order
    int    errors, checks, tests, failed_tests, test_errors;
    int    in_credits = `DOT_IN_CREDITS;    // Producer view of free slots
    int    pairs_sent, credit_pulses;
    int    results_seen, credits_back;
    int    hold_target, hold_seen, release_wait;
    bit    hold_active, timed_out, test_open;
    string test_name;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(4)) u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    dot_product_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_in_valid   (in_valid),
        .i_in_pair    (in_pair),
        .o_in_credit  (in_credit),
        .o_out_valid  (out_valid),
        .o_out_result (out_result),
        .i_out_credit (out_credit)
    );

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t after %0d cycles waiting for %s", $time, WAIT_LIMIT, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Waits for a credit, then drives one pair for a single cycle
    task automatic push_pair(input int a, input int b, input int last);
        int            gap;
        int            waited;
        bit            sent;
        operand_pair_t p;
        gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;  // Mostly bursts
        waited = 0;
        sent = 1'b0;
        p.a = operand_t'(a);
        p.b = operand_t'(b);
        p.last = last[0];
        while (!timed_out && !sent && waited < WAIT_LIMIT) begin
            @(posedge clk);
            if (gap == 0 && in_credits > 0) begin
                in_valid <= 1'b1;
                in_pair <= p;
                in_credits--;
                pairs_sent++;
                sent = 1'b1;
            end else begin
                in_valid <= 1'b0;
                if (gap > 0) gap--;
                else waited++;
            end
        end
        if (!timed_out && !sent) give_up("an input credit");
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!timed_out && waited < WAIT_LIMIT &&
               (exp_q.size() != 0 || hold_active || results_seen != credits_back)) begin
            idle_cycle();
            waited++;
        end
        if (!timed_out && waited >= WAIT_LIMIT) give_up("all results and output credits");
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
        test_open = 1'b1;
    endtask

    task automatic finish_test();
        drain();
        if (!timed_out && in_credits != `DOT_IN_CREDITS) begin
            report_mismatch($sformatf("producer holds %0d input credits", in_credits));
        end
        if (!timed_out && credit_pulses != pairs_sent) begin
            report_mismatch($sformatf("%0d credits for %0d pairs", credit_pulses, pairs_sent));
        end
        tests++;
        if (errors != test_errors) begin
            failed_tests++;
            $display("Test %s: FAILED with %0d errors", test_name, errors - test_errors);
        end else begin
            $display("Test %s: passed", test_name);
        end
        test_open = 1'b0;
    endtask

    // Result and credit monitor on the falling edge
    always @(negedge clk) begin : monitor
        dot_result_t exp_res;
        if (!rst) begin
            credits_back += int'(out_credit);
            if (out_valid) begin
                results_seen++;
                if (hold_active) begin
                    hold_seen++;
                    if (hold_seen > `DOT_OUT_CREDITS) begin
                        report_mismatch("result sent without an output credit");
                    end
                end
                if (exp_q.size() == 0) begin
                    $display("Result arrived at %0t with none outstanding", $time);
                    errors++;
                end else begin
                    exp_res = exp_q.pop_front();
                    checks++;
                    if (out_result !== exp_res) begin
                        report_mismatch($sformatf("got sum %0d terms %0d, expected %0d terms %0d",
                            out_result.sum, out_result.terms, exp_res.sum, exp_res.terms));
                    end
                end
            end
            if (hold_active && hold_seen >= hold_target) begin
                if (release_wait == 0) hold_active = 1'b0;
                else release_wait--;
            end
            if (in_credit) begin
                in_credits++;
                credit_pulses++;
                if (in_credits > `DOT_IN_CREDITS) report_mismatch("input credit beyond depth");
            end
        end
    end

    // Consumer returns one credit per result after a short random delay
    always @(posedge clk) begin : credit_return
        int delay;
        if (rst) begin
            out_credit <= 1'b0;
            delay = 0;
        end else begin
            out_credit <= 1'b0;
            if (!hold_active && results_seen > credits_back) begin
                if (delay == 0) begin
                    out_credit <= 1'b1;
                    delay = $urandom_range(0, 4);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : run
        int          fd;
        int          code;
        int          waited;
        int          a, b, last, exp_sum, exp_terms, hold_n;
        int          model_sum, model_terms;
        string       tok, line;
        dot_result_t exp_res;
        code = $urandom(32'h7393b13b);
        model_sum = 0;
        model_terms = 0;
        start_test("reset");
        @(negedge clk);
        waited = 0;
        while (rst === 1'b1 && waited < WAIT_LIMIT) begin
            if (out_valid !== 1'b0 || in_credit !== 1'b0) report_mismatch("output high in reset");
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) give_up("reset to drop");
        repeat (3) begin
            if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
                report_mismatch("output high after reset");
            end
            @(negedge clk);
        end
        finish_test();

        fd = $fopen("dv/dot_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/dot_vectors.txt");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    code = $fgets(line, fd);    // Rest of a comment line
                end else if (tok == "T") begin
                    code = $fscanf(fd, "%s", line);
                    if (test_open) finish_test();
                    start_test(line);
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%d %d %d", a, b, last);
                    push_pair(a, b, last);
                    model_sum += a * b;         // 32-bit int wraps like the sum
                    model_terms++;
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%d %d", exp_sum, exp_terms);
                    if (exp_sum != model_sum || exp_terms != model_terms % 256) begin
                        report_mismatch($sformatf("file expects %0d/%0d, model has %0d/%0d",
                            exp_sum, exp_terms, model_sum, model_terms));
                    end
                    exp_res.sum = acc_t'(exp_sum);
                    exp_res.terms = term_count_t'(exp_terms);
                    exp_q.push_back(exp_res);
                    model_sum = 0;
                    model_terms = 0;
                end else if (tok == "H") begin
                    code = $fscanf(fd, "%d", hold_n);
                    drain();
                    hold_target = hold_n;
                    hold_seen = 0;
                    release_wait = $urandom_range(20, 40);
                    hold_active = 1'b1;
                end else begin
                    $display("Unknown record %s in vector file", tok);
                    errors++;
                end
            end
            $fclose(fd);
        end
        if (test_open) finish_test();

        $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Reset released on a rising edge
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* hdl/dot_product_top.sv */
`timescale 1ns/100ps

module dot_product_top import dot_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_in_valid,
    input  operand_pair_t i_in_pair,
    output logic          o_in_credit,
    output logic          o_out_valid,
    output dot_result_t   o_out_result,
    input  logic          i_out_credit
);

    // Buffer to MAC
    logic          pair_valid;
    operand_pair_t pair;
    logic          mac_ready;

    // MAC to sender
    logic          res_valid;
    dot_result_t   res;
    logic          res_accept;

    operand_fifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .i_push       (i_in_valid),
        .i_pair       (i_in_pair),
        .i_pop_ready  (mac_ready),
        .o_pair_valid (pair_valid),
        .o_pair       (pair),
        .o_credit     (o_in_credit)     // Credit per popped pair
    );

    mac_accum u_mac (
        .clk          (clk),
        .rst          (rst),
        .i_pair_valid (pair_valid),
        .i_pair       (pair),
        .o_ready      (mac_ready),
        .o_res_valid  (res_valid),
        .o_res        (res),
        .i_res_accept (res_accept)
    );

    result_sender u_sender (
        .clk          (clk),
        .rst          (rst),
        .i_res_valid  (res_valid),
        .i_res        (res),
        .o_accept     (res_accept),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_out_result (o_out_result)
    );

endmodule

/* hdl/result_sender.sv */
`timescale 1ns/100ps
`include "dot_settings.svh"

module result_sender import dot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_res_valid,
    input  dot_result_t i_res,
    output logic        o_accept,
    input  logic        i_out_credit,
    output logic        o_out_valid,
    output dot_result_t o_out_result
);

    localparam int CRD_W = $clog2(`DOT_OUT_CREDITS + 1);

    logic        hold_valid;
    dot_result_t hold_res;
    logic [CRD_W-1:0] credits;
    logic send;

    assign o_accept = !hold_valid;
    assign send     = hold_valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid  <= 1'b0;
            o_out_valid <= 1'b0;
            credits     <= CRD_W'(`DOT_OUT_CREDITS);
        end else begin
            o_out_valid <= send;    // One-cycle pulse per result
            if (i_res_valid && o_accept) begin
                hold_valid <= 1'b1;
            end else if (send) begin
                hold_valid <= 1'b0;
            end
            // Returned credit in a send cycle cancels out
            case ({send, i_out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_res_valid && o_accept) begin
            hold_res <= i_res;
        end
        if (send) begin
            o_out_result <= hold_res;
        end
    end

    // Consumer returned more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= CRD_W'(`DOT_OUT_CREDITS));

endmodule

/* hdl/mac_accum.sv */
`timescale 1ns/100ps

module mac_accum import dot_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_pair_valid,
    input  operand_pair_t i_pair,
    output logic          o_ready,
    output logic          o_res_valid,
    output dot_result_t   o_res,
    input  logic          i_res_accept
);

    // Stage 1 operand register
    logic          s1_valid;
    operand_pair_t s1_pair;

    // Stage 2 accumulator state
    acc_t        acc;
    term_count_t terms;

    acc_t        product;
    acc_t        sum_next;
    term_count_t terms_next;
    logic        pop;
    logic        s2_fire;

    // A new pair only enters when no result is waiting
    assign o_ready = !o_res_valid;
    assign pop     = i_pair_valid && o_ready;

    // A closing pair must wait until the result register is free
    assign s2_fire = s1_valid && (!s1_pair.last || !o_res_valid || i_res_accept);

    // Signed 16x16 product fits in 32 bits
    assign product    = acc_t'(s1_pair.a) * acc_t'(s1_pair.b);
    assign sum_next   = acc + product;      // Wraps
    assign terms_next = terms + term_count_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (pop) begin
            s1_valid <= 1'b1;
        end else if (s2_fire) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_pair <= i_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            terms       <= '0;
            o_res_valid <= 1'b0;
        end else begin
            if (o_res_valid && i_res_accept) begin
                o_res_valid <= 1'b0;
            end
            if (s2_fire) begin
                if (s1_pair.last) begin
                    acc         <= '0;      // Fresh start for next vector
                    terms       <= '0;
                    o_res_valid <= 1'b1;
                end else begin
                    acc   <= sum_next;
                    terms <= terms_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_fire && s1_pair.last) begin
            o_res.sum   <= sum_next;
            o_res.terms <= terms_next;
        end
    end

    // Pending result holds until the sender takes it
    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        (o_res_valid && !i_res_accept) |=> (o_res_valid && $stable(o_res)));

endmodule

/* hdl/operand_fifo.sv */
`timescale 1ns/100ps
`include "dot_settings.svh"

module operand_fifo import dot_pkg::*; #(
    parameter int DEPTH = `DOT_IN_CREDITS
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_push,
    input  operand_pair_t i_pair,
    input  logic          i_pop_ready,
    output logic          o_pair_valid,
    output operand_pair_t o_pair,
    output logic          o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    operand_pair_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic pop;

    assign o_pair_valid = (count != '0);
    assign o_pair       = mem[rd_ptr];
    assign pop          = o_pair_valid && i_pop_ready;
    assign o_credit     = pop;          // Freed slot goes straight back to producer

    // Pair storage
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Producer pushed without a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(i_push && count == CNT_W'(DEPTH)));

    // Empty means pointers agree, so no pop ran past the writes
    a_no_underrun: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

/* hdl/dot_pkg.sv */
`include "dot_settings.svh"

package dot_pkg;

    // One signed factor
    typedef logic signed [`DOT_OPERAND_W-1:0] operand_t;

    // Running or final sum wrapping modulo 2^32
    typedef logic signed [`DOT_ACC_W-1:0] acc_t;

    // Terms per vector wrapping after 255
    typedef logic [`DOT_COUNT_W-1:0] term_count_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     last;     // Closes the vector
    } operand_pair_t;

    typedef struct packed {
        acc_t        sum;
        term_count_t terms;
    } dot_result_t;

endpackage

/* hdl/dot_settings.svh */
`ifndef DOT_SETTINGS_SVH
`define DOT_SETTINGS_SVH

// Datapath widths
`define DOT_OPERAND_W   16
`define DOT_ACC_W       32
`define DOT_COUNT_W     8

// Credit depths on either side of the engine
`define DOT_IN_CREDITS  4   // Input buffer slots
`define DOT_OUT_CREDITS 2   // Results the consumer can take up front

`endif
